/* sim.f */
rtl/hxd_pkg.sv
rtl/hxd_stage_if.sv
rtl/hxd_fetch.sv
rtl/hxd_regfile.sv
rtl/hxd_decode.sv
rtl/hxd_execute.sv
rtl/hxd_memory.sv
rtl/hxd32.sv
verif/hxd32_tb.sv

/* run.sh */
#!/bin/sh
# Build the hxd32 testbench with Verilator, run it, and decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -j 0 --top-module hxd32_tb -f sim.f -o hxd32_sim > build.log 2>&1 \
    && ./obj_dir/hxd32_sim > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/hxd32_tb.sv */
/*
 * hxd32 testbench
 * Runs a small self-checking program through the core. Every acknowledged
 * data write is checked against a table built from the ISA rules, while
 * the Wishbone model inserts random wait states
 */

module hxd32_tb;

timeunit 1ns;
timeprecision 100ps;

localparam logic [31:0] RESET_PC       = 32'h0000_0000;
localparam logic [31:0] RESULT_BASE    = 32'h0000_0200;
localparam logic [31:0] FILL_ADDR      = 32'h0000_0600;
localparam logic [31:0] POISON_ADDR    = 32'h0000_07F0;
localparam logic [31:0] DONE_ADDR      = 32'h0000_07FC;
localparam int          TIMEOUT_CYCLES = 5000;

logic        clk_i;
logic        reset_i;
logic [31:0] iram_rd_addr_o;
logic [31:0] iram_rd_data_i;
logic        dwb_cyc_o;
logic        dwb_stb_o;
logic        dwb_we_o;
logic [31:0] dwb_adr_o;
logic [31:0] dwb_dat_o;
logic [31:0] dwb_dat_i;
logic        dwb_ack_i;

logic [31:0] imem [256];
logic [31:0] prog [$];
logic [31:0] rf [32];                    // Architectural registers after each emitted instruction
logic [31:0] exp_mem [logic [31:0]];
logic [31:0] dmem [logic [31:0]];
logic [63:0] exp_q [$];                  // {address, data} in program order
logic [31:0] slot;
logic        done_seen = 1'b0;
int          val_errs = 0;
int          other_errs = 0;

hxd32 #(
    .RESET_PC(RESET_PC)
) i_hxd32 (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .iram_rd_data_i(iram_rd_data_i),
    .iram_rd_addr_o(iram_rd_addr_o),
    .dwb_cyc_o(dwb_cyc_o),
    .dwb_stb_o(dwb_stb_o),
    .dwb_we_o(dwb_we_o),
    .dwb_adr_o(dwb_adr_o),
    .dwb_dat_o(dwb_dat_o),
    .dwb_dat_i(dwb_dat_i),
    .dwb_ack_i(dwb_ack_i)
);

assign iram_rd_data_i = imem[iram_rd_addr_o[9:2]];   // Same-cycle instruction read

initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
end

// Background for data words never written
function automatic logic [31:0] fill_word(logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h6b3d_92e5;
endfunction

// RV32I integer semantics with funct3 selecting the operation
function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt)
                return $unsigned($signed(a) >>> b[4:0]);
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic [31:0] enc_sw(int rs2, logic [11:0] off);
    return {off[11:5], 5'(rs2), 5'd0, 3'd2, off[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_jal(int rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'(rd), 7'b1101111};
endfunction

task automatic set_reg(int rd, logic [31:0] v);
    if (rd != 0)
        rf[rd[4:0]] = v;
endtask

task automatic sw_at(int rs2, logic [31:0] addr);
    prog.push_back(enc_sw(rs2, addr[11:0]));
    if (addr != POISON_ADDR) begin
        exp_q.push_back({addr, rf[rs2[4:0]]});
        exp_mem[addr] = rf[rs2[4:0]];
    end
endtask

task automatic store_result(int rs2);
    sw_at(rs2, slot);
    slot = slot + 32'd4;
endtask

task automatic lui(int rd, logic [19:0] imm);
    prog.push_back({imm, 5'(rd), 7'b0110111});
    set_reg(rd, {imm, 12'd0});
    store_result(rd);
endtask

// Each ALU result is stored right behind it as a back-to-back dependency
task automatic op_r(logic alt, logic [2:0] f3, int rd, int rs1, int rs2);
    prog.push_back({1'b0, alt, 5'd0, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011});
    set_reg(rd, alu_ref(f3, alt, rf[rs1[4:0]], rf[rs2[4:0]]));
    store_result(rd);
endtask

task automatic op_i(logic [2:0] f3, int rd, int rs1, logic [11:0] imm);
    prog.push_back({imm, 5'(rs1), f3, 5'(rd), 7'b0010011});
    set_reg(rd, alu_ref(f3, f3 == 3'd5 && imm[10], rf[rs1[4:0]], {{20{imm[11]}}, imm}));
    store_result(rd);
endtask

task automatic lw(int rd, logic [31:0] addr);
    prog.push_back({addr[11:0], 5'd0, 3'd2, 5'(rd), 7'b0000011});
    set_reg(rd, exp_mem.exists(addr) ? exp_mem[addr] : fill_word(addr));
endtask

// Branch over two slots; they hold poison stores only when the branch is taken
task automatic branch_test(logic [2:0] f3, int rs1, int rs2);
    logic        taken;
    logic [12:0] off;
    off = 13'd12;
    case (f3)
        3'd0:    taken = rf[rs1[4:0]] == rf[rs2[4:0]];
        3'd1:    taken = rf[rs1[4:0]] != rf[rs2[4:0]];
        default: taken = $signed(rf[rs1[4:0]]) < $signed(rf[rs2[4:0]]);
    endcase
    prog.push_back({off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11],
                    7'b1100011});
    if (taken) begin
        sw_at(0, POISON_ADDR);
        sw_at(0, POISON_ADDR);
    end else begin
        store_result(rs1);
        store_result(rs2);
    end
endtask

task automatic jal_test(int rd);
    logic [31:0] pc;
    pc = 32'(prog.size()) << 2;
    prog.push_back(enc_jal(rd, 21'd12));
    set_reg(rd, pc + 32'd4);
    sw_at(0, POISON_ADDR);
    sw_at(0, POISON_ADDR);
    store_result(rd);
endtask

task automatic build_program();
    rf[0] = 32'd0;
    slot  = RESULT_BASE;
    lui(1, 20'h80000);
    op_i(3'd0, 2, 0, 12'hFFB);           // x2 = -5
    op_i(3'd0, 3, 0, 12'h007);
    op_r(1'b1, 3'd0, 4, 3, 2);           // SUB
    op_r(1'b0, 3'd2, 5, 2, 3);           // SLT negative against positive
    op_r(1'b0, 3'd2, 5, 3, 2);
    op_i(3'd2, 6, 2, 12'hFFA);
    op_i(3'd5, 7, 1, {7'b0100000, 5'd4});    // SRAI
    op_i(3'd5, 8, 1, {7'b0000000, 5'd4});
    op_i(3'd1, 9, 3, 12'h003);
    op_i(3'd4, 10, 2, 12'h0F0);
    op_i(3'd6, 11, 3, 12'h100);
    op_i(3'd7, 12, 2, 12'h0FF);
    op_r(1'b0, 3'd0, 13, 2, 3);
    op_r(1'b0, 3'd4, 13, 2, 3);
    op_r(1'b0, 3'd6, 13, 1, 3);
    op_r(1'b0, 3'd7, 13, 2, 10);
    op_r(1'b0, 3'd1, 13, 3, 3);
    op_r(1'b0, 3'd5, 13, 1, 3);
    op_r(1'b1, 3'd5, 13, 1, 3);          // SRA
    op_i(3'd0, 14, 0, 12'h001);
    op_r(1'b0, 3'd0, 14, 14, 14);
    op_r(1'b0, 3'd0, 14, 14, 14);
    lw(15, slot - 32'd4);                // Reads back the last stored word
    op_r(1'b0, 3'd0, 16, 15, 15);        // Load then use
    lw(18, FILL_ADDR);
    op_r(1'b0, 3'd4, 19, 18, 3);
    branch_test(3'd0, 3, 3);
    branch_test(3'd0, 2, 3);
    branch_test(3'd1, 2, 3);
    branch_test(3'd1, 3, 3);
    branch_test(3'd4, 1, 3);
    branch_test(3'd4, 3, 2);
    jal_test(17);
    sw_at(3, DONE_ADDR);
    prog.push_back(enc_jal(0, 21'd0));   // Spin here
endtask

task automatic record_write();
    logic [63:0] entry;
    dmem[dwb_adr_o] = dwb_dat_o;
    if (dwb_adr_o == DONE_ADDR)
        done_seen = 1'b1;
    assert (dwb_adr_o != POISON_ADDR)
    else begin
        other_errs++;
        $display("a write to the poison address was acknowledged at %0t ns", $time);
    end
    assert (exp_q.size() != 0)
    else begin
        other_errs++;
        $display("more writes arrived than the program makes, address %h", dwb_adr_o);
    end
    if (exp_q.size() != 0) begin
        entry = exp_q.pop_front();
        assert ({dwb_adr_o, dwb_dat_o} == entry)
        else begin
            val_errs++;
            $display("ERR %0t write %h = %h, expected %h = %h", $time,
                     dwb_adr_o, dwb_dat_o, entry[63:32], entry[31:0]);
        end
    end
endtask

task automatic check_reset_state();
    assert (!dwb_cyc_o && !dwb_stb_o && iram_rd_addr_o == RESET_PC)
    else begin
        val_errs++;
        $display("ERR %0t reset state cyc %b stb %b pc %h", $time,
                 dwb_cyc_o, dwb_stb_o, iram_rd_addr_o);
    end
endtask

// Wishbone slave with 0 to 3 wait states per access
initial begin : data_memory
    int unsigned waits_left;
    logic        in_access;
    void'($urandom(54));
    waits_left = 0;
    in_access  = 1'b0;
    dwb_ack_i  = 1'b0;
    dwb_dat_i  = '0;
    forever begin
        @(posedge clk_i);
        #1;
        if (dwb_ack_i) begin
            dwb_ack_i = 1'b0;
            in_access = 1'b0;
        end else if (dwb_cyc_o && dwb_stb_o) begin
            if (!in_access) begin
                in_access  = 1'b1;
                waits_left = $urandom % 4;
            end
            if (waits_left != 0) begin
                waits_left--;
            end else begin
                if (dwb_we_o)
                    record_write();
                else
                    dwb_dat_i = dmem.exists(dwb_adr_o) ? dmem[dwb_adr_o] : fill_word(dwb_adr_o);
                dwb_ack_i = 1'b1;
            end
        end
    end
end

assert property (@(posedge clk_i) disable iff (reset_i)
    dwb_stb_o && !dwb_ack_i |=> $stable(dwb_adr_o) && $stable(dwb_we_o) && $stable(dwb_dat_o))
else begin
    val_errs++;
    $display("ERR %0t bus changed in a wait state, adr %h we %b dat %h", $time,
             dwb_adr_o, dwb_we_o, dwb_dat_o);
end

initial begin
    int cycles;
    reset_i = 1'b1;
    for (int i = 0; i < 256; i++)
        imem[i[7:0]] = enc_sw(0, POISON_ADDR[11:0]);   // Trap for runaway fetch
    build_program();
    foreach (prog[i])
        imem[i[7:0]] = prog[i];
    repeat (16) begin
        @(posedge clk_i);
        #1;
        check_reset_state();
    end
    reset_i = 1'b0;
    #1;
    check_reset_state();
    cycles = 0;
    while (!done_seen && cycles < TIMEOUT_CYCLES) begin
        @(posedge clk_i);
        cycles++;
    end
    if (!done_seen) begin
        other_errs++;
        $display("timeout, no write to the done address after %0d cycles", cycles);
    end
    repeat (8) @(posedge clk_i);          // Spin loop must stay silent
    assert (exp_q.size() == 0)
    else begin
        other_errs++;
        $display("%0d expected writes never arrived", exp_q.size());
    end
    $display("value errors %0d, other errors %0d", val_errs, other_errs);
    if (val_errs == 0 && other_errs == 0)
        $display("ALL TESTS PASSED");
    else
        $display("SOME TESTS FAILED");
    $finish;
end

endmodule

/* rtl/hxd32.sv */
/*
 * hxd32 top level
 * Four-stage RV32I subset core: fetch, decode, execute,
 * memory/writeback; instruction RAM port and Wishbone data port
 */

module hxd32 #(
    parameter logic [31:0] RESET_PC = hxd_pkg::RESET_PC_DEFAULT
) (
    input  logic        clk_i,
    input  logic        reset_i,

    input  logic [31:0] iram_rd_data_i,
    output logic [31:0] iram_rd_addr_o,

    output logic        dwb_cyc_o,
    output logic        dwb_stb_o,
    output logic        dwb_we_o,
    output logic [31:0] dwb_adr_o,
    output logic [31:0] dwb_dat_o,
    input  logic [31:0] dwb_dat_i,
    input  logic        dwb_ack_i
);

logic        stall;
logic        redirect;
logic [31:0] redirect_pc;

logic        inst_valid;
logic [31:0] inst_pc;
logic [31:0] inst;

logic        wb_en;
logic [4:0]  wb_rd;
logic [31:0] wb_data;

logic [4:0]  mem_rd;
logic        mem_busy;

hxd_dec_exe_if dec_exe ();
hxd_exe_mem_if exe_mem ();

hxd_fetch #(
    .RESET_PC(RESET_PC)
) u_fetch (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .stall_i(stall),
    .redirect_i(redirect),
    .redirect_pc_i(redirect_pc),
    .iram_rd_data_i(iram_rd_data_i),
    .iram_rd_addr_o(iram_rd_addr_o),
    .inst_valid_o(inst_valid),
    .inst_pc_o(inst_pc),
    .inst_o(inst)
);

hxd_decode u_decode (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .inst_valid_i(inst_valid),
    .inst_pc_i(inst_pc),
    .inst_i(inst),
    .redirect_i(redirect),
    .wb_en_i(wb_en),
    .wb_rd_i(wb_rd),
    .wb_data_i(wb_data),
    .mem_rd_i(mem_rd),
    .mem_busy_i(mem_busy),
    .stall_o(stall),
    .exe(dec_exe.src)
);

hxd_execute u_execute (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .dec(dec_exe.dst),
    .mem(exe_mem.src),
    .redirect_o(redirect),
    .redirect_pc_o(redirect_pc)
);

hxd_memory u_memory (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .exe(exe_mem.dst),
    .dwb_cyc_o(dwb_cyc_o),
    .dwb_stb_o(dwb_stb_o),
    .dwb_we_o(dwb_we_o),
    .dwb_adr_o(dwb_adr_o),
    .dwb_dat_o(dwb_dat_o),
    .dwb_dat_i(dwb_dat_i),
    .dwb_ack_i(dwb_ack_i),
    .wb_en_o(wb_en),
    .wb_rd_o(wb_rd),
    .wb_data_o(wb_data),
    .mem_rd_o(mem_rd),
    .mem_busy_o(mem_busy)
);

endmodule

/* rtl/hxd_memory.sv */
/*
 * hxd32 memory and writeback stage
 * Wishbone classic master for word loads and stores,
 * retires ALU results and load data into the register file
 */

module hxd_memory (
    input  logic        clk_i,
    input  logic        reset_i,

    hxd_exe_mem_if.dst  exe,

    output logic        dwb_cyc_o,
    output logic        dwb_stb_o,
    output logic        dwb_we_o,
    output logic [31:0] dwb_adr_o,
    output logic [31:0] dwb_dat_o,
    input  logic [31:0] dwb_dat_i,
    input  logic        dwb_ack_i,

    output logic        wb_en_o,
    output logic [4:0]  wb_rd_o,
    output logic [31:0] wb_data_o,

    output logic [4:0]  mem_rd_o,
    output logic        mem_busy_o
);

typedef enum logic {
    ST_IDLE,
    ST_WAIT
} state_e;

state_e state;
logic   is_mem;
logic   done;

assign is_mem = exe.valid && exe.mem != hxd_pkg::MEM_NONE;
assign done   = state == ST_WAIT && dwb_ack_i;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        state <= ST_IDLE;
    end else begin
        case (state)
            ST_IDLE: if (is_mem) state <= ST_WAIT;
            ST_WAIT: if (dwb_ack_i) state <= ST_IDLE;   // cyc drops next cycle
            default: state <= ST_IDLE;
        endcase
    end
end

// Execute holds its register while we wait, so these stay stable
assign dwb_cyc_o = state == ST_WAIT;
assign dwb_stb_o = state == ST_WAIT;
assign dwb_we_o  = exe.mem == hxd_pkg::MEM_STORE;
assign dwb_adr_o = exe.result;
assign dwb_dat_o = exe.store_data;

assign exe.ready = !is_mem || done;

assign wb_en_o   = exe.valid && (exe.mem == hxd_pkg::MEM_NONE ||
                                 (exe.mem == hxd_pkg::MEM_LOAD && done));
assign wb_rd_o   = exe.rd;
assign wb_data_o = (exe.mem == hxd_pkg::MEM_LOAD) ? dwb_dat_i : exe.result;

assign mem_rd_o   = exe.rd;
assign mem_busy_o = exe.valid;

assert property (@(posedge clk_i) disable iff (reset_i)
    dwb_cyc_o |-> is_mem)
    else $error("bus cycle without a memory item");

assert property (@(posedge clk_i) disable iff (reset_i)
    dwb_stb_o && !dwb_ack_i |=> $stable(dwb_adr_o) && $stable(dwb_we_o))
    else $error("address or we changed before ack");

endmodule

/* rtl/hxd_execute.sv */
/*
 * hxd32 execute stage
 * ALU, branch compare and redirect, register into memory stage
 */

module hxd_execute (
    input  logic        clk_i,
    input  logic        reset_i,

    hxd_dec_exe_if.dst  dec,
    hxd_exe_mem_if.src  mem,

    output logic        redirect_o,
    output logic [31:0] redirect_pc_o
);

logic [31:0] op_a;
logic [31:0] op_b;
logic [4:0]  shamt;
logic [31:0] alu_res;
logic        taken;

assign op_a  = dec.rs1_val;
assign op_b  = dec.use_imm ? dec.imm : dec.rs2_val;
assign shamt = op_b[4:0];

always_comb begin
    case (dec.alu_op)
        hxd_pkg::ALU_SUB:    alu_res = op_a - op_b;
        hxd_pkg::ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
        hxd_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
        hxd_pkg::ALU_OR:     alu_res = op_a | op_b;
        hxd_pkg::ALU_AND:    alu_res = op_a & op_b;
        hxd_pkg::ALU_SLL:    alu_res = op_a << shamt;
        hxd_pkg::ALU_SRL:    alu_res = op_a >> shamt;
        hxd_pkg::ALU_SRA:    alu_res = $unsigned($signed(op_a) >>> shamt);
        hxd_pkg::ALU_PASS_B: alu_res = op_b;   // LUI
        default:             alu_res = op_a + op_b;
    endcase
end

// Conditions always compare rs1 with rs2, not the immediate
always_comb begin
    case (dec.br)
        hxd_pkg::BR_BEQ: taken = dec.rs1_val == dec.rs2_val;
        hxd_pkg::BR_BNE: taken = dec.rs1_val != dec.rs2_val;
        hxd_pkg::BR_BLT: taken = $signed(dec.rs1_val) < $signed(dec.rs2_val);
        hxd_pkg::BR_JAL: taken = 1'b1;
        default:         taken = 1'b0;
    endcase
end

assign dec.ready     = !mem.valid || mem.ready;
assign redirect_o    = dec.valid && dec.ready && taken;   // Only when the item moves on
assign redirect_pc_o = dec.pc + dec.imm;

always_ff @(posedge clk_i) begin
    if (reset_i)
        mem.valid <= 1'b0;
    else if (dec.ready)
        mem.valid <= dec.valid;
end

always_ff @(posedge clk_i) begin
    if (dec.ready && dec.valid) begin
        mem.result     <= (dec.br == hxd_pkg::BR_JAL) ? dec.pc + 32'd4 : alu_res;
        mem.store_data <= dec.rs2_val;
        mem.rd         <= dec.rd;
        mem.mem        <= dec.mem;
    end
end

endmodule

/* rtl/hxd_decode.sv */
/*
 * hxd32 decode stage
 * Field and immediate decode, register read, RAW interlock
 * against execute and memory, issue register into execute
 */

module hxd_decode (
    input  logic        clk_i,
    input  logic        reset_i,

    input  logic        inst_valid_i,
    input  logic [31:0] inst_pc_i,
    input  logic [31:0] inst_i,

    input  logic        redirect_i,

    input  logic        wb_en_i,
    input  logic [4:0]  wb_rd_i,
    input  logic [31:0] wb_data_i,

    input  logic [4:0]  mem_rd_i,
    input  logic        mem_busy_i,

    output logic        stall_o,

    hxd_dec_exe_if.src  exe
);

hxd_pkg::hxd_inst_u   inst;
logic [31:0]          rs1_val;
logic [31:0]          rs2_val;
logic [31:0]          imm;
logic [4:0]           rd;
hxd_pkg::hxd_alu_op_e alu_op;
logic                 use_imm;
logic                 use_rs1;
logic                 use_rs2;
hxd_pkg::hxd_br_e     br;
hxd_pkg::hxd_mem_e    mem;
logic                 rs1_hit;
logic                 rs2_hit;
logic                 issue;

assign inst = inst_i;

hxd_regfile u_regfile (
    .clk_i(clk_i),
    .reset_i(reset_i),
    .rs1_i(inst.r.rs1),
    .rs2_i(inst.r.rs2),
    .rs1_val_o(rs1_val),
    .rs2_val_o(rs2_val),
    .wb_en_i(wb_en_i),
    .wb_rd_i(wb_rd_i),
    .wb_data_i(wb_data_i)
);

// Shared by OP and OP-IMM where alt selects SUB or SRA
function automatic hxd_pkg::hxd_alu_op_e alu_sel(logic [2:0] funct3, logic alt);
    case (funct3)
        3'd0:    return alt ? hxd_pkg::ALU_SUB : hxd_pkg::ALU_ADD;
        3'd1:    return hxd_pkg::ALU_SLL;
        3'd2:    return hxd_pkg::ALU_SLT;
        3'd4:    return hxd_pkg::ALU_XOR;
        3'd5:    return alt ? hxd_pkg::ALU_SRA : hxd_pkg::ALU_SRL;
        3'd6:    return hxd_pkg::ALU_OR;
        default: return hxd_pkg::ALU_AND;
    endcase
endfunction

always_comb begin
    imm     = '0;
    rd      = '0;     // Unsupported opcodes fall through as no-ops
    alu_op  = hxd_pkg::ALU_ADD;
    use_imm = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    br      = hxd_pkg::BR_NONE;
    mem     = hxd_pkg::MEM_NONE;
    case (inst.r.opcode)
        hxd_pkg::OPC_OP: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            alu_op  = alu_sel(inst.r.funct3, inst.r.funct7[5]);
            rd      = (inst.r.funct3 == 3'd3) ? 5'd0 : inst.r.rd;   // No SLTU
        end
        hxd_pkg::OPC_OP_IMM: begin
            use_rs1 = 1'b1;
            use_imm = 1'b1;
            imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
            alu_op  = alu_sel(inst.r.funct3, inst.r.funct3 == 3'd5 && inst.r.funct7[5]);
            rd      = (inst.r.funct3 == 3'd3) ? 5'd0 : inst.r.rd;
        end
        hxd_pkg::OPC_LUI: begin
            use_imm = 1'b1;
            imm     = {inst.u.imm, 12'd0};
            alu_op  = hxd_pkg::ALU_PASS_B;
            rd      = inst.u.rd;
        end
        hxd_pkg::OPC_JAL: begin
            imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                   inst.j.imm11, inst.j.imm10_1, 1'b0};
            br  = hxd_pkg::BR_JAL;
            rd  = inst.j.rd;
        end
        hxd_pkg::OPC_BRANCH: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            imm     = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                       inst.b.imm10_5, inst.b.imm4_1, 1'b0};
            case (inst.b.funct3)
                3'd0:    br = hxd_pkg::BR_BEQ;
                3'd1:    br = hxd_pkg::BR_BNE;
                3'd4:    br = hxd_pkg::BR_BLT;
                default: br = hxd_pkg::BR_NONE;
            endcase
        end
        hxd_pkg::OPC_LOAD: begin
            use_rs1 = 1'b1;
            use_imm = 1'b1;
            imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
            mem     = hxd_pkg::MEM_LOAD;
            rd      = inst.i.rd;
        end
        hxd_pkg::OPC_STORE: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
            use_imm = 1'b1;
            imm     = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
            mem     = hxd_pkg::MEM_STORE;
        end
        default: ;
    endcase
end

// Pending writes in execute or memory block the read
assign rs1_hit = use_rs1 && inst.r.rs1 != 5'd0 &&
                 ((exe.valid && exe.rd == inst.r.rs1) ||
                  (mem_busy_i && mem_rd_i == inst.r.rs1));
assign rs2_hit = use_rs2 && inst.r.rs2 != 5'd0 &&
                 ((exe.valid && exe.rd == inst.r.rs2) ||
                  (mem_busy_i && mem_rd_i == inst.r.rs2));

assign issue   = inst_valid_i && !rs1_hit && !rs2_hit && !redirect_i;
assign stall_o = inst_valid_i && (rs1_hit || rs2_hit || !exe.ready);

always_ff @(posedge clk_i) begin
    if (reset_i)
        exe.valid <= 1'b0;
    else if (exe.ready)
        exe.valid <= issue;   // Squashed on redirect
end

always_ff @(posedge clk_i) begin
    if (exe.ready && issue) begin
        exe.pc      <= inst_pc_i;
        exe.rs1_val <= rs1_val;
        exe.rs2_val <= rs2_val;
        exe.imm     <= imm;
        exe.rd      <= rd;
        exe.alu_op  <= alu_op;
        exe.use_imm <= use_imm;
        exe.br      <= br;
        exe.mem     <= mem;
    end
end

assert property (@(posedge clk_i) disable iff (reset_i)
    exe.valid && (exe.mem == hxd_pkg::MEM_STORE ||
                  exe.br inside {hxd_pkg::BR_BEQ, hxd_pkg::BR_BNE, hxd_pkg::BR_BLT})
    |-> exe.rd == 5'd0)
    else $error("store or branch issued with rd %0d", exe.rd);

endmodule

/* rtl/hxd_regfile.sv */
/*
 * hxd32 register file
 * x1..x31, two combinational reads, one write; x0 reads zero
 */

module hxd_regfile (
    input  logic        clk_i,
    input  logic        reset_i,

    input  logic [4:0]  rs1_i,
    input  logic [4:0]  rs2_i,
    output logic [31:0] rs1_val_o,
    output logic [31:0] rs2_val_o,

    input  logic        wb_en_i,
    input  logic [4:0]  wb_rd_i,
    input  logic [31:0] wb_data_i
);

logic [31:0] regs [1:31];

assign rs1_val_o = (rs1_i == 5'd0) ? 32'd0 : regs[rs1_i];
assign rs2_val_o = (rs2_i == 5'd0) ? 32'd0 : regs[rs2_i];

always_ff @(posedge clk_i) begin
    if (!reset_i && wb_en_i && wb_rd_i != 5'd0)   // Writes to x0 dropped
        regs[wb_rd_i] <= wb_data_i;
end

endmodule

/* rtl/hxd_fetch.sv */
/*
 * hxd32 fetch stage
 * Program counter with redirect, same-cycle instruction read,
 * and the fetch-to-decode instruction register
 */

module hxd_fetch #(
    parameter logic [31:0] RESET_PC = hxd_pkg::RESET_PC_DEFAULT
) (
    input  logic        clk_i,
    input  logic        reset_i,

    input  logic        stall_i,
    input  logic        redirect_i,
    input  logic [31:0] redirect_pc_i,

    input  logic [31:0] iram_rd_data_i,
    output logic [31:0] iram_rd_addr_o,

    output logic        inst_valid_o,
    output logic [31:0] inst_pc_o,
    output logic [31:0] inst_o
);

logic [31:0] pc;

assign iram_rd_addr_o = pc;

always_ff @(posedge clk_i) begin
    if (reset_i) begin
        pc           <= RESET_PC;
        inst_valid_o <= 1'b0;
    end else if (redirect_i) begin   // Redirect wins over stall
        pc           <= redirect_pc_i;
        inst_valid_o <= 1'b0;
    end else if (!stall_i) begin
        pc           <= pc + 32'd4;
        inst_valid_o <= 1'b1;
    end
end

always_ff @(posedge clk_i) begin
    if (!stall_i && !redirect_i) begin
        inst_pc_o <= pc;
        inst_o    <= iram_rd_data_i;
    end
end

assert property (@(posedge clk_i) disable iff (reset_i)
    redirect_i |-> redirect_pc_i[1:0] == 2'b00)
    else $error("misaligned redirect target %h", redirect_pc_i);

endmodule

/* rtl/hxd_stage_if.sv */
/*
 * hxd32 stage-to-stage handshakes
 * Decode to execute and execute to memory, valid/ready,
 * an item moves when both are high
 */

interface hxd_dec_exe_if;
    logic                 valid;
    logic                 ready;
    logic [31:0]          pc;
    logic [31:0]          rs1_val;
    logic [31:0]          rs2_val;
    logic [31:0]          imm;
    logic [4:0]           rd;
    hxd_pkg::hxd_alu_op_e alu_op;
    logic                 use_imm;  // Operand b from imm instead of rs2
    hxd_pkg::hxd_br_e     br;
    hxd_pkg::hxd_mem_e    mem;

    modport src (
        output valid, pc, rs1_val, rs2_val, imm, rd, alu_op, use_imm, br, mem,
        input  ready
    );
    modport dst (
        input  valid, pc, rs1_val, rs2_val, imm, rd, alu_op, use_imm, br, mem,
        output ready
    );
endinterface

interface hxd_exe_mem_if;
    logic              valid;
    logic              ready;
    logic [31:0]       result;      // ALU result, load/store address or link
    logic [31:0]       store_data;
    logic [4:0]        rd;
    hxd_pkg::hxd_mem_e mem;

    modport src (
        output valid, result, store_data, rd, mem,
        input  ready
    );
    modport dst (
        input  valid, result, store_data, rd, mem,
        output ready
    );
endinterface

/* rtl/hxd_pkg.sv */
/*
 * hxd32 shared definitions
 * Instruction word views, opcode constants, ALU operation,
 * branch kind and memory action encodings, reset PC default
 */

package hxd_pkg;

localparam logic [31:0] RESET_PC_DEFAULT = 32'h0000_0000;

localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;

typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
} hxd_r_t;

typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} hxd_i_t;

typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
} hxd_s_t;

typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
} hxd_b_t;

typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
} hxd_u_t;

typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
} hxd_j_t;

typedef union packed {
    hxd_r_t r;
    hxd_i_t i;
    hxd_s_t s;
    hxd_b_t b;
    hxd_u_t u;
    hxd_j_t j;
} hxd_inst_u;

typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLT, ALU_XOR, ALU_OR,
    ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
} hxd_alu_op_e;

typedef enum logic [2:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_JAL
} hxd_br_e;

typedef enum logic [1:0] {
    MEM_NONE, MEM_LOAD, MEM_STORE
} hxd_mem_e;

endpackage
